/* Makefile */
# verilator build and run of the stream merger testbench

.PHONY: help test clean

help:
	@echo "make test   build with verilator, run, and check sim.log for the pass line"
	@echo "make clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert --top-module merge_tb -f tb.f -Mdir obj_dir -o merge_sim
	./obj_dir/merge_sim +verilator+error+limit+100 > sim.log 2>&1 ; cat sim.log
	@grep -q "^STATUS: PASS$$" sim.log || (echo "simulation failed, see sim.log" && exit 1)

clean:
	rm -rf obj_dir sim.log

/* rtl/fifo_core.sv */
`timescale 1ns/1ps

// standard fifo, read data one cycle behind pop
module fifo_core (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              flush,
    input  logic                              push,
    input  logic                              pop,
    input  logic [merge_pkg::data_width-1:0]  din,
    output logic [merge_pkg::data_width-1:0]  dout,
    output logic                              empty,
    output logic                              full,
    output logic [merge_pkg::count_width-1:0] count
);
    import merge_pkg::*;

    // ********************************************************************
    // pointers and qualified strobes
    // ********************************************************************
    logic [addr_width-1:0] wr_ptr;
    logic [addr_width-1:0] rd_ptr;
    logic                  push_ok;       // push that actually stores
    logic                  pop_ok;        // pop that actually reads

    assign push_ok = push && !full;       // push while full dropped
    assign pop_ok  = pop && !empty;       // pop while empty dropped

    // flags come straight from the count
    assign full  = (count == count_width'(fifo_depth));
    assign empty = (count == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin         // sync clear, wins over push/pop
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, pop_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    // ********************************************************************
    // storage
    // ********************************************************************
    fifo_ram fifo_ram_inst (
        .clk     (clk),
        .wr_en   (push_ok),
        .wr_addr (wr_ptr),
        .wr_data (din),
        .rd_en   (pop_ok),
        .rd_addr (rd_ptr),
        .rd_data (dout)       // valid the cycle after pop_ok
    );

endmodule

/* rtl/fifo_fwft.sv */
`timescale 1ns/1ps

// head word stays visible on dout while empty is low
module fifo_fwft (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              flush,
    input  logic                              push,
    input  logic                              pop,
    input  logic [merge_pkg::data_width-1:0]  din,
    output logic [merge_pkg::data_width-1:0]  dout,
    output logic                              empty,
    output logic                              full,
    output logic [merge_pkg::count_width-1:0] count
);
    import merge_pkg::*;

    logic                  core_pop;      // prefetch strobe into core
    logic                  core_empty;
    logic [data_width-1:0] core_dout;
    logic                  dout_valid;    // head word present

    // prefetch when head slot free or being taken this cycle
    assign core_pop = !core_empty && (!dout_valid || pop);
    assign empty    = !dout_valid;
    assign dout     = core_dout;          // ram output holds the head

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dout_valid <= 1'b0;
        end else if (flush) begin
            dout_valid <= 1'b0;           // drop the head too
        end else if (core_pop) begin
            dout_valid <= 1'b1;           // next word arrives on this edge
        end else if (pop) begin
            dout_valid <= 1'b0;           // head taken, nothing behind it
        end
    end

    // ********************************************************************
    // underlying fifo
    // ********************************************************************
    fifo_core fifo_core_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .push  (push),
        .pop   (core_pop),
        .din   (din),
        .dout  (core_dout),
        .empty (core_empty),
        .full  (full),                    // core full, head slot not counted
        .count (count)
    );

endmodule

/* rtl/fifo_ram.sv */
`timescale 1ns/1ps

// simple dual-port storage with one write and one registered read port
module fifo_ram (
    input  logic                             clk,
    input  logic                             wr_en,
    input  logic [merge_pkg::addr_width-1:0] wr_addr,
    input  logic [merge_pkg::data_width-1:0] wr_data,
    input  logic                             rd_en,
    input  logic [merge_pkg::addr_width-1:0] rd_addr,
    output logic [merge_pkg::data_width-1:0] rd_data
);
    import merge_pkg::*;

    // ********************************************************************
    // storage
    // ********************************************************************
    logic [data_width-1:0] mem [fifo_depth];   // one word per slot

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;            // lands on this edge
        end
    end

    // ********************************************************************
    // read port
    // ********************************************************************
    // data shows up one cycle after rd_en
    // holds its last value between reads so the fwft head stays put
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* rtl/lane_merger.sv */
`timescale 1ns/1ps

// round-robin pick of two fwft lanes onto a four-phase req/ack port
module lane_merger (
    input  logic                             clk,
    input  logic                             rst_n,
    input  logic [merge_pkg::data_width-1:0] dout_a,
    input  logic                             empty_a,
    input  logic [merge_pkg::data_width-1:0] dout_b,
    input  logic                             empty_b,
    output logic                             pop_a,
    output logic                             pop_b,
    output logic                             out_req,
    input  logic                             out_ack,
    output logic [merge_pkg::data_width-1:0] out_data,
    output logic                             out_lane
);
    import merge_pkg::*;

    // ********************************************************************
    // lane choice
    // ********************************************************************
    logic [1:0]            state;
    logic                  last_lane;     // 0 = a served last, 1 = b
    logic                  any_ready;
    logic                  sel_lane;      // lane picked this cycle
    logic                  take;          // idle and something to take
    logic [data_width-1:0] sel_data;

    assign any_ready = !empty_a || !empty_b;

    // only one lane ready -> that one, both -> not the last one served
    always_comb begin
        if (empty_a) begin
            sel_lane = 1'b1;
        end else if (empty_b) begin
            sel_lane = 1'b0;
        end else begin
            sel_lane = !last_lane;
        end
    end

    assign sel_data = sel_lane ? dout_b : dout_a;
    assign take     = (state == st_idle) && any_ready;

    // pop lands on the same edge the word is latched
    assign pop_a = take && !sel_lane;
    assign pop_b = take && sel_lane;

    // ********************************************************************
    // handshake fsm
    // ********************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            out_req   <= 1'b0;
            out_lane  <= 1'b0;
            last_lane <= 1'b1;            // lane a gets the first tie
        end else begin
            case (state)
                st_idle: begin
                    if (any_ready) begin
                        out_req   <= 1'b1;
                        out_lane  <= sel_lane;
                        last_lane <= sel_lane;
                        state     <= st_ack_hi;
                    end
                end
                st_ack_hi: begin
                    if (out_ack) begin    // sink has the word
                        out_req <= 1'b0;
                        state   <= st_ack_lo;
                    end
                end
                st_ack_lo: begin
                    if (!out_ack) begin   // phase four done
                        state <= st_idle;
                    end
                end
                default: begin
                    out_req <= 1'b0;
                    state   <= st_idle;
                end
            endcase
        end
    end

    // payload, only moves when a lane is taken
    always_ff @(posedge clk) begin
        if (take) begin
            out_data <= sel_data;
        end
    end

endmodule

/* rtl/merge_pkg.sv */
package merge_pkg;

    // payload word
    localparam int data_width  = 16;

    // fifo pointer width sets the depth
    localparam int addr_width  = 3;
    localparam int fifo_depth  = 1 << addr_width;   // 8 entries

    // occupancy needs one extra bit to reach fifo_depth
    localparam int count_width = addr_width + 1;

    // ********************************************************************
    // merger fsm encodings
    // ********************************************************************
    localparam logic [1:0] st_idle   = 2'd0;    // free to pick a lane
    localparam logic [1:0] st_ack_hi = 2'd1;    // req up until ack rises
    localparam logic [1:0] st_ack_lo = 2'd2;    // req down until ack drops

endpackage

/* rtl/merge_top.sv */
`timescale 1ns/1ps

// two lane fifos feeding the merger
module merge_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              flush,
    input  logic                              push_a,
    input  logic [merge_pkg::data_width-1:0]  din_a,
    output logic                              full_a,
    output logic [merge_pkg::count_width-1:0] count_a,
    input  logic                              push_b,
    input  logic [merge_pkg::data_width-1:0]  din_b,
    output logic                              full_b,
    output logic [merge_pkg::count_width-1:0] count_b,
    output logic                              out_req,
    input  logic                              out_ack,
    output logic [merge_pkg::data_width-1:0]  out_data,
    output logic                              out_lane
);
    import merge_pkg::*;

    // ********************************************************************
    // fifo to merger wiring
    // ********************************************************************
    logic [data_width-1:0] dout_a;
    logic [data_width-1:0] dout_b;
    logic                  empty_a;
    logic                  empty_b;
    logic                  pop_a;
    logic                  pop_b;

    fifo_fwft lane_a_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .push  (push_a),
        .pop   (pop_a),
        .din   (din_a),
        .dout  (dout_a),
        .empty (empty_a),
        .full  (full_a),
        .count (count_a)
    );

    fifo_fwft lane_b_fifo (
        .clk   (clk),
        .rst_n (rst_n),
        .flush (flush),
        .push  (push_b),
        .pop   (pop_b),
        .din   (din_b),
        .dout  (dout_b),
        .empty (empty_b),
        .full  (full_b),
        .count (count_b)
    );

    lane_merger lane_merger_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .dout_a   (dout_a),
        .empty_a  (empty_a),
        .dout_b   (dout_b),
        .empty_b  (empty_b),
        .pop_a    (pop_a),
        .pop_b    (pop_b),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .out_data (out_data),
        .out_lane (out_lane)   // 0 = lane a, 1 = lane b
    );

endmodule

/* tb.f */
rtl/merge_pkg.sv
rtl/fifo_ram.sv
rtl/fifo_core.sv
rtl/fifo_fwft.sv
rtl/lane_merger.sv
rtl/merge_top.sv
test/merge_properties.sv
test/merge_tb.sv

/* test/merge_properties.sv */
`timescale 1ns/1ps

// four-phase rules on the merger output port
module merge_properties (
    input logic                             clk,
    input logic                             rst_n,
    input logic                             out_req,
    input logic                             out_ack,
    input logic [merge_pkg::data_width-1:0] out_data,
    input logic                             out_lane
);
    int violations = 0;                     // failed assertions so far

    // req may only drop once ack is up
    assert property (@(posedge clk) disable iff (!rst_n) $fell(out_req) |-> $past(out_ack))
    else begin
        violations++;
        $error("out_req fell while out_ack was low");
    end

    // no new request until the sink let go of ack
    assert property (@(posedge clk) disable iff (!rst_n) $rose(out_req) |-> !$past(out_ack))
    else begin
        violations++;
        $error("out_req rose while out_ack was high");
    end

    // payload frozen for the whole request
    assert property (@(posedge clk) disable iff (!rst_n)
        out_req && $past(out_req) |-> $stable(out_data) && $stable(out_lane))
    else begin
        violations++;
        $error("out_data or out_lane changed while out_req was high");
    end

endmodule

bind lane_merger merge_properties merge_properties_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .out_req  (out_req),
    .out_ack  (out_ack),
    .out_data (out_data),
    .out_lane (out_lane)
);

/* test/merge_tb.sv */
`timescale 1ns/1ps

// random sources into the merger with a per-lane scoreboard and a random-delay sink
module merge_tb;
    import merge_pkg::*;

    logic                   clk, rst_n, flush;
    logic                   push_a, push_b, full_a, full_b;
    logic [data_width-1:0]  din_a, din_b, out_data;
    logic [count_width-1:0] count_a, count_b;
    logic                   out_req, out_ack, out_lane;

    logic [data_width-1:0]  exp_a[$];       // words still owed in push order
    logic [data_width-1:0]  exp_b[$];
    logic [31:0]            rng = 32'h1c0b_fbff;
    string                  test_name = "reset";
    int                     errors = 0;
    int                     checks = 0;
    int                     accepted_a = 0;
    logic                   ack_hold = 1'b0;    // sink stalls while set
    logic                   rr_check = 1'b0;    // lanes must alternate
    logic                   have_last = 1'b0;
    logic                   last_lane = 1'b0;
    logic                   saw_full_a = 1'b0;

    merge_top merge_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;             // 20 ns period
    end

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);            // xorshift32
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // **********************************************************************
    // checks and helpers
    // **********************************************************************
    task automatic check_value(input string what, input logic [data_width-1:0] exp,
                               input logic [data_width-1:0] act);
        checks++;
        assert (act == exp) else begin
            errors++;
            $display("Fail %s %s: expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%s: %s", test_name, what);
        end
    endtask

    task automatic abort_run(input string what);
        $display("%s: timed out %s", test_name, what);
        $display("checks %0d, errors %0d", checks, errors + 1);
        $display("STATUS: FAIL");
        $finish;
    endtask

    // one source cycle from 1 ns after a rising edge to 1 ns after the next
    task automatic drive_cycle(input logic pa, input logic pb);
        push_a = pa;
        push_b = pb;
        din_a  = data_width'(next_rand());
        din_b  = data_width'(next_rand());
        @(negedge clk);                     // full as the next edge sees it
        if (push_a && !full_a) begin
            exp_a.push_back(din_a);
            accepted_a++;
        end
        if (push_b && !full_b) begin
            exp_b.push_back(din_b);
        end
        saw_full_a = saw_full_a | full_a;
        @(posedge clk);
        #1;
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        do begin
            @(negedge clk);                 // quiet point between edges
            t++;
        end while ((exp_a.size() + exp_b.size() != 0 || out_req || out_ack) && t < 2000);
        @(posedge clk);
        #1;
        if (t >= 2000) begin
            abort_run("waiting for the output to drain");
        end
    endtask

    // one-cycle flush pulse that also clears the owed words
    task automatic flush_lanes();
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        exp_a.delete();
        exp_b.delete();
    endtask

    // **********************************************************************
    // scoreboard compares once per rising out_req
    // **********************************************************************
    initial begin : scoreboard
        logic prev_req;
        prev_req = 1'b0;
        forever begin
            @(posedge clk);                 // pre-edge values
            if (!rr_check) begin
                have_last = 1'b0;
            end else if (out_req && !prev_req) begin
                check_true(!have_last || out_lane != last_lane, "same lane served twice in a row");
                have_last = 1'b1;
                last_lane = out_lane;
            end
            if (out_req && !prev_req) begin
                check_true((out_lane ? exp_b.size() : exp_a.size()) != 0,
                           "word arrived with none pending on its lane");
                if (!out_lane && exp_a.size() != 0) begin
                    check_value("lane a word", exp_a.pop_front(), out_data);
                end else if (out_lane && exp_b.size() != 0) begin
                    check_value("lane b word", exp_b.pop_front(), out_data);
                end
            end
            prev_req = out_req;
        end
    end

    // sink side of the four-phase handshake
    initial begin : ack_responder
        int t;
        out_ack = 1'b0;
        forever begin
            @(posedge clk);
            if (out_req && !ack_hold) begin
                repeat (int'(next_rand() & 32'd3)) @(posedge clk);
                #1 out_ack = 1'b1;
                t = 0;
                while (out_req && t < 50) begin
                    @(posedge clk);
                    t++;
                end
                if (t >= 50) begin
                    abort_run("waiting for out_req to fall");
                end else begin
                    repeat (int'(next_rand() & 32'd3)) @(posedge clk);
                    #1 out_ack = 1'b0;
                end
            end
        end
    end

    initial begin : main
        logic [31:0] r;
        rst_n  = 1'b0;
        flush  = 1'b0;
        push_a = 1'b0;
        push_b = 1'b0;
        din_a  = '0;
        din_b  = '0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        check_value("reset outputs", '0, data_width'({out_req, full_a, full_b, count_a, count_b}));

        test_name = "lane_order";           // random traffic with random ack delays
        repeat (150) begin
            r = next_rand();
            drive_cycle(r[0] & r[1], r[2] & r[3]);
        end
        push_a = 1'b0;
        push_b = 1'b0;
        wait_drained();

        test_name = "round_robin";          // both lanes loaded before the first choice
        ack_hold = 1'b1;
        rr_check = 1'b1;
        repeat (6) drive_cycle(1'b1, 1'b1);
        push_a   = 1'b0;
        push_b   = 1'b0;
        ack_hold = 1'b0;
        wait_drained();
        rr_check = 1'b0;

        test_name = "back_pressure";        // 10 words fit in merger, head and core
        ack_hold = 1'b1;
        accepted_a = 0;
        saw_full_a = 1'b0;
        repeat (12) drive_cycle(1'b1, 1'b0);
        push_a = 1'b0;
        check_value("accepted words", data_width'(10), data_width'(accepted_a));
        check_true(saw_full_a, "full_a never rose with out_ack held low");
        ack_hold = 1'b0;
        wait_drained();

        test_name = "flush";                // both lanes full behind a stalled word
        ack_hold = 1'b1;
        repeat (12) drive_cycle(1'b1, 1'b1);
        push_a = 1'b0;
        push_b = 1'b0;
        flush_lanes();
        check_value("counts and full", '0, data_width'({count_a, count_b, full_a, full_b}));
        ack_hold = 1'b0;
        wait_drained();                     // held word still goes out
        drive_cycle(1'b1, 1'b1);            // idle merger, head not yet valid
        push_a = 1'b0;
        push_b = 1'b0;
        flush_lanes();
        repeat (20) begin
            @(negedge clk);
            check_true(!out_req, "out_req rose after flush with nothing pushed");
        end

        errors = errors + merge_top_inst.lane_merger_inst.merge_properties_inst.violations;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
